//--- Bender.yml
package:
  name: camera_reader

sources:
  # shared package first
  - common/camera_pkg.sv
  # pixel path
  - pixel/pixel_reconstruct.sv
  - pixel/rgb_to_ycrcb.sv
  # frame buffer
  - frame_buffer/fb_write_router.sv
  - frame_buffer/fb_bank.sv
  - frame_buffer/fb_read_scheduler.sv
  # top level
  - design/camera_reader.sv
  # testbench
  - target: test
    files:
      - verification/camera_reader_sva.sv
      - verification/camera_reader_tb.sv

//--- common/camera_pkg.sv
package camera_pkg;

    // stored camera pixel, rgb565 with red in the top bits
    typedef logic [15:0] pixel565_t;

    // one 8-bit colour, luma or chroma channel
    typedef logic [7:0] chan_t;

    // full-resolution camera coordinates
    typedef logic [10:0] hcount_t;
    typedef logic [9:0] vcount_t;

    // linear frame-buffer address, covers 320x180
    typedef logic [16:0] fb_addr_t;

    // luma weights
    localparam logic signed [8:0] Y_R = 9'sd66;
    localparam logic signed [8:0] Y_G = 9'sd129;
    localparam logic signed [8:0] Y_B = 9'sd25;

    // red-difference chroma weights
    localparam logic signed [8:0] CR_R = 9'sd112;
    localparam logic signed [8:0] CR_G = -9'sd94;
    localparam logic signed [8:0] CR_B = -9'sd18;

    // blue-difference chroma weights
    localparam logic signed [8:0] CB_R = -9'sd38;
    localparam logic signed [8:0] CB_G = -9'sd74;
    localparam logic signed [8:0] CB_B = 9'sd112;

    // offsets added after the rounding shift
    localparam int Y_OFS = 16;
    localparam int C_OFS = 128;

endpackage

//--- design/camera_reader.sv
module camera_reader #(
    parameter int FB_W        = 320,
    parameter int FB_H        = 180,
    parameter int DS          = 4,
    parameter int BANKS       = 4,
    parameter int REQ_DEPTH   = 4,
    parameter int OUT_CREDITS = 4
) (
    input  logic                 clk_camera,
    input  logic                 sys_rst_camera,
    input  logic [7:0]           camera_d,
    input  logic                 cam_pclk,
    input  logic                 cam_hsync,
    input  logic                 cam_vsync,
    input  logic                 pattern_enable,
    input  logic                 rd_req_valid,
    input  camera_pkg::fb_addr_t rd_req_addr,
    input  logic                 out_credit,
    output logic                 rd_req_credit,
    output logic                 out_valid,
    output camera_pkg::chan_t    red,
    output camera_pkg::chan_t    green,
    output camera_pkg::chan_t    blue,
    output camera_pkg::chan_t    y,
    output camera_pkg::chan_t    cr,
    output camera_pkg::chan_t    cb
);

    // each bank holds every BANKS-th pixel
    localparam int BANK_DEPTH = (FB_W * FB_H + BANKS - 1) / BANKS;
    localparam int AW = $clog2(BANK_DEPTH);

    // full-resolution pixel stream
    logic px_valid;
    camera_pkg::pixel565_t px_data;
    camera_pkg::hcount_t px_hcount;
    camera_pkg::vcount_t px_vcount;
    logic frame_start;

    // write side
    logic [BANKS-1:0] wr_en;
    logic [AW-1:0] wr_addr;
    camera_pkg::pixel565_t wr_data;

    // read side
    logic [AW-1:0] rd_addr;
    camera_pkg::pixel565_t bank_rd_data [BANKS];
    logic rgb_valid;
    camera_pkg::chan_t fb_red;
    camera_pkg::chan_t fb_green;
    camera_pkg::chan_t fb_blue;

    pixel_reconstruct u_pixel_reconstruct (
        .clk_camera     (clk_camera),
        .sys_rst_camera (sys_rst_camera),
        .camera_d       (camera_d),
        .cam_pclk       (cam_pclk),
        .cam_hsync      (cam_hsync),
        .cam_vsync      (cam_vsync),
        .px_valid       (px_valid),
        .px_data        (px_data),
        .px_hcount      (px_hcount),
        .px_vcount      (px_vcount),
        .frame_start    (frame_start)
    );

    fb_write_router #(
        .FB_W  (FB_W),
        .FB_H  (FB_H),
        .DS    (DS),
        .BANKS (BANKS)
    ) u_fb_write_router (
        .clk_camera     (clk_camera),
        .sys_rst_camera (sys_rst_camera),
        .px_valid       (px_valid),
        .px_data        (px_data),
        .px_hcount      (px_hcount),
        .px_vcount      (px_vcount),
        .frame_start    (frame_start),
        .pattern_enable (pattern_enable),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data)
    );

    // shared address and data, private write enable per bank
    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        fb_bank #(
            .DEPTH (BANK_DEPTH)
        ) u_fb_bank (
            .clk_camera (clk_camera),
            .wr_en      (wr_en[b]),
            .wr_addr    (wr_addr),
            .wr_data    (wr_data),
            .rd_addr    (rd_addr),
            .rd_data    (bank_rd_data[b])
        );
    end

    fb_read_scheduler #(
        .FB_W        (FB_W),
        .FB_H        (FB_H),
        .BANKS       (BANKS),
        .REQ_DEPTH   (REQ_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_fb_read_scheduler (
        .clk_camera     (clk_camera),
        .sys_rst_camera (sys_rst_camera),
        .rd_req_valid   (rd_req_valid),
        .rd_req_addr    (rd_req_addr),
        .out_credit     (out_credit),
        .rd_data        (bank_rd_data),
        .rd_req_credit  (rd_req_credit),
        .rd_addr        (rd_addr),
        .rgb_valid      (rgb_valid),
        .red            (fb_red),
        .green          (fb_green),
        .blue           (fb_blue)
    );

    // three more cycles, so out_valid lands five after dequeue
    rgb_to_ycrcb u_rgb_to_ycrcb (
        .clk_camera     (clk_camera),
        .sys_rst_camera (sys_rst_camera),
        .rgb_valid      (rgb_valid),
        .red            (fb_red),
        .green          (fb_green),
        .blue           (fb_blue),
        .out_valid      (out_valid),
        .red_out        (red),
        .green_out      (green),
        .blue_out       (blue),
        .y              (y),
        .cr             (cr),
        .cb             (cb)
    );

endmodule

//--- frame_buffer/fb_bank.sv
module fb_bank #(
    parameter int DEPTH = 14400,
    localparam int AW = $clog2(DEPTH)
) (
    input  logic                  clk_camera,
    input  logic                  wr_en,
    input  logic [AW-1:0]         wr_addr,
    input  camera_pkg::pixel565_t wr_data,
    input  logic [AW-1:0]         rd_addr,
    output camera_pkg::pixel565_t rd_data
);

    // one slice of the frame buffer
    camera_pkg::pixel565_t mem [DEPTH];

    always_ff @(posedge clk_camera) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, data one cycle after the address
    always_ff @(posedge clk_camera) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- frame_buffer/fb_read_scheduler.sv
module fb_read_scheduler #(
    parameter int FB_W        = 320,
    parameter int FB_H        = 180,
    parameter int BANKS       = 4,
    parameter int REQ_DEPTH   = 4,
    parameter int OUT_CREDITS = 4,
    localparam int BANK_DEPTH = (FB_W * FB_H + BANKS - 1) / BANKS,
    localparam int AW = $clog2(BANK_DEPTH)
) (
    input  logic                  clk_camera,
    input  logic                  sys_rst_camera,
    input  logic                  rd_req_valid,
    input  camera_pkg::fb_addr_t  rd_req_addr,
    input  logic                  out_credit,
    input  camera_pkg::pixel565_t rd_data [BANKS],
    output logic                  rd_req_credit,
    output logic [AW-1:0]         rd_addr,
    output logic                  rgb_valid,
    output camera_pkg::chan_t     red,
    output camera_pkg::chan_t     green,
    output camera_pkg::chan_t     blue
);

    localparam int QPW = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
    localparam int CW  = $clog2(REQ_DEPTH + 1);
    localparam int OCW = $clog2(OUT_CREDITS + 1);
    localparam int BW  = (BANKS > 1) ? $clog2(BANKS) : 1;

    // request queue, no full check since the requester holds credits
    camera_pkg::fb_addr_t queue [REQ_DEPTH];
    logic [QPW-1:0] wr_ptr;
    logic [QPW-1:0] rd_ptr;
    logic [CW-1:0] q_count;
    logic [OCW-1:0] credits;

    camera_pkg::fb_addr_t head;
    camera_pkg::pixel565_t sel;
    logic deq;
    logic s1_valid;
    logic s1_in_frame;
    logic [BW-1:0] s1_bank;

    assign head = queue[rd_ptr];
    // one dequeue per cycle while an output credit is held
    assign deq = (q_count != '0) && (credits != '0);
    // every bank sees the same local address
    assign rd_addr = AW'(head / BANKS);

    always_ff @(posedge clk_camera) begin
        if (rd_req_valid) begin
            queue[wr_ptr] <= rd_req_addr;
        end
    end

    always_ff @(posedge clk_camera) begin
        if (sys_rst_camera) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            q_count <= '0;
            credits <= OCW'(OUT_CREDITS);
            rd_req_credit <= 1'b0;
            s1_valid <= 1'b0;
            rgb_valid <= 1'b0;
        end else begin
            if (rd_req_valid) begin
                wr_ptr <= (wr_ptr == QPW'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (deq) begin
                rd_ptr <= (rd_ptr == QPW'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            q_count <= q_count + CW'(rd_req_valid) - CW'(deq);
            credits <= credits + OCW'(out_credit) - OCW'(deq);
            // freed queue slot goes back to the requester
            rd_req_credit <= deq;
            s1_valid <= deq;
            rgb_valid <= s1_valid;
        end
    end

    // bank select and range flag follow the ram read by one cycle
    always_ff @(posedge clk_camera) begin
        s1_bank <= BW'(head % BANKS);
        s1_in_frame <= head < FB_W * FB_H;
    end

    assign sel = rd_data[s1_bank];

    // 565 to 888, zero fill in the low bits
    always_ff @(posedge clk_camera) begin
        if (s1_in_frame) begin
            red <= {sel[15:11], 3'b000};
            green <= {sel[10:5], 2'b00};
            blue <= {sel[4:0], 3'b000};
        end else begin
            red <= '0;
            green <= '0;
            blue <= '0;
        end
    end

endmodule

//--- frame_buffer/fb_write_router.sv
module fb_write_router #(
    parameter int FB_W  = 320,
    parameter int FB_H  = 180,
    parameter int DS    = 4,
    parameter int BANKS = 4,
    localparam int BANK_DEPTH = (FB_W * FB_H + BANKS - 1) / BANKS,
    localparam int AW = $clog2(BANK_DEPTH)
) (
    input  logic                  clk_camera,
    input  logic                  sys_rst_camera,
    input  logic                  px_valid,
    input  camera_pkg::pixel565_t px_data,
    input  camera_pkg::hcount_t   px_hcount,
    input  camera_pkg::vcount_t   px_vcount,
    input  logic                  frame_start,
    input  logic                  pattern_enable,
    output logic [BANKS-1:0]      wr_en,
    output logic [AW-1:0]         wr_addr,
    output camera_pkg::pixel565_t wr_data
);

    localparam int DS_SH = $clog2(DS);

    camera_pkg::hcount_t col;
    camera_pkg::vcount_t row;
    camera_pkg::fb_addr_t lin_addr;
    camera_pkg::vcount_t pattern_row;
    camera_pkg::pixel565_t pat_pixel;
    logic keep;

    // downsampled coordinates
    assign col = px_hcount >> DS_SH;
    assign row = px_vcount >> DS_SH;
    assign lin_addr = camera_pkg::fb_addr_t'(row * FB_W + col);

    // only grid points that land inside the buffer are stored
    assign keep = px_valid && (px_hcount % DS == 0) && (px_vcount % DS == 0)
                  && (col < FB_W) && (row < FB_H);

    // white above the moving row, black below
    assign pat_pixel = (row < pattern_row) ? 16'hFFFF : 16'h0000;

    always_ff @(posedge clk_camera) begin
        if (sys_rst_camera) begin
            wr_en <= '0;
            pattern_row <= '0;
        end else begin
            wr_en <= '0;
            // bank is the address modulo the bank count
            if (keep) begin
                wr_en[lin_addr % BANKS] <= 1'b1;
            end
            if (frame_start) begin
                pattern_row <= (pattern_row == FB_H - 1) ? '0 : pattern_row + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_camera) begin
        if (keep) begin
            wr_addr <= AW'(lin_addr / BANKS);
            wr_data <= pattern_enable ? pat_pixel : px_data;
        end
    end

endmodule

//--- pixel/pixel_reconstruct.sv
module pixel_reconstruct (
    input  logic                clk_camera,
    input  logic                sys_rst_camera,
    input  logic [7:0]          camera_d,
    input  logic                cam_pclk,
    input  logic                cam_hsync,
    input  logic                cam_vsync,
    output logic                px_valid,
    output camera_pkg::pixel565_t px_data,
    output camera_pkg::hcount_t px_hcount,
    output camera_pkg::vcount_t px_vcount,
    output logic                frame_start
);

    // two sync flops per line, a third one for edge detection
    logic [2:0] pclk_sr;
    logic [2:0] hs_sr;
    logic [2:0] vs_sr;
    logic [7:0] d_s0;
    logic [7:0] d_s1;

    logic pclk_rise;
    logic hs;
    logic hs_fall;
    logic vs;
    logic vs_fall;

    // byte phase, 0 waits for the high byte
    logic phase;
    logic [7:0] hi_byte;
    camera_pkg::hcount_t hcount;
    camera_pkg::vcount_t vcount;

    // data lines line up with pclk_sr[1]
    assign pclk_rise = pclk_sr[1] & ~pclk_sr[2];
    assign hs = hs_sr[1];
    assign hs_fall = hs_sr[2] & ~hs_sr[1];
    assign vs = vs_sr[1];
    assign vs_fall = vs_sr[2] & ~vs_sr[1];

    always_ff @(posedge clk_camera) begin
        d_s0 <= camera_d;
        d_s1 <= d_s0;
    end

    always_ff @(posedge clk_camera) begin
        if (sys_rst_camera) begin
            pclk_sr <= '0;
            hs_sr <= '0;
            vs_sr <= '0;
            px_valid <= 1'b0;
            frame_start <= 1'b0;
            phase <= 1'b0;
            hcount <= '0;
            vcount <= '0;
        end else begin
            pclk_sr <= {pclk_sr[1:0], cam_pclk};
            hs_sr <= {hs_sr[1:0], cam_hsync};
            vs_sr <= {vs_sr[1:0], cam_vsync};
            px_valid <= 1'b0;
            frame_start <= vs_fall;
            // column restarts whenever hsync is low
            if (!hs) begin
                phase <= 1'b0;
                hcount <= '0;
            end else if (pclk_rise) begin
                phase <= ~phase;
                if (phase) begin
                    px_valid <= 1'b1;
                    hcount <= hcount + 1'b1;
                end
            end
            // row advances at the end of each line
            if (!vs) begin
                vcount <= '0;
            end else if (hs_fall) begin
                vcount <= vcount + 1'b1;
            end
        end
    end

    // pixel payload, first byte is the high half
    always_ff @(posedge clk_camera) begin
        if (hs && pclk_rise) begin
            if (!phase) begin
                hi_byte <= d_s1;
            end else begin
                px_data <= {hi_byte, d_s1};
                px_hcount <= hcount;
                px_vcount <= vcount;
            end
        end
    end

endmodule

//--- pixel/rgb_to_ycrcb.sv
module rgb_to_ycrcb (
    input  logic              clk_camera,
    input  logic              sys_rst_camera,
    input  logic              rgb_valid,
    input  camera_pkg::chan_t red,
    input  camera_pkg::chan_t green,
    input  camera_pkg::chan_t blue,
    output logic              out_valid,
    output camera_pkg::chan_t red_out,
    output camera_pkg::chan_t green_out,
    output camera_pkg::chan_t blue_out,
    output camera_pkg::chan_t y,
    output camera_pkg::chan_t cr,
    output camera_pkg::chan_t cb
);

    // rows are y, cr, cb; columns are r, g, b
    localparam logic signed [8:0] COEF [3][3] = '{
        '{camera_pkg::Y_R, camera_pkg::Y_G, camera_pkg::Y_B},
        '{camera_pkg::CR_R, camera_pkg::CR_G, camera_pkg::CR_B},
        '{camera_pkg::CB_R, camera_pkg::CB_G, camera_pkg::CB_B}
    };
    localparam int OFS [3] = '{camera_pkg::Y_OFS, camera_pkg::C_OFS, camera_pkg::C_OFS};

    logic signed [8:0] chan_in [3];
    logic signed [17:0] prod [3][3];
    logic signed [19:0] sum [3];
    logic [2:0] valid_sr;
    camera_pkg::chan_t rgb_sr [3][3];

    // clamp to the 0..255 range
    function automatic camera_pkg::chan_t sat8(input logic signed [19:0] v);
        if (v < 0) begin
            return 8'd0;
        end else if (v > 255) begin
            return 8'd255;
        end
        return v[7:0];
    endfunction

    // zero-extended so the channels multiply as positive values
    assign chan_in[0] = $signed({1'b0, red});
    assign chan_in[1] = $signed({1'b0, green});
    assign chan_in[2] = $signed({1'b0, blue});

    always_ff @(posedge clk_camera) begin
        // stage 1, nine products
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                prod[i][j] <= chan_in[j] * COEF[i][j];
            end
        end
        // stage 2, weighted sum with rounding
        for (int i = 0; i < 3; i++) begin
            sum[i] <= (prod[i][0] + prod[i][1] + prod[i][2] + 20'sd128) >>> 8;
        end
        // stage 3, offset and saturate
        y <= sat8(20'(sum[0] + OFS[0]));
        cr <= sat8(20'(sum[1] + OFS[1]));
        cb <= sat8(20'(sum[2] + OFS[2]));
        // rgb rides along beside the math
        rgb_sr[0] <= '{red, green, blue};
        rgb_sr[1] <= rgb_sr[0];
        rgb_sr[2] <= rgb_sr[1];
    end

    assign red_out = rgb_sr[2][0];
    assign green_out = rgb_sr[2][1];
    assign blue_out = rgb_sr[2][2];

    always_ff @(posedge clk_camera) begin
        if (sys_rst_camera) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[1:0], rgb_valid};
        end
    end

    assign out_valid = valid_sr[2];

endmodule

//--- verification/camera_reader_sva.sv
module camera_reader_sva #(
    parameter int BANKS       = 4,
    parameter int REQ_DEPTH   = 4,
    parameter int OUT_CREDITS = 4
) (
    input logic                clk_camera,
    input logic                sys_rst_camera,
    input logic                rd_req_valid,
    input logic                rd_req_credit,
    input logic                out_valid,
    input logic                out_credit,
    input logic [BANKS-1:0]    wr_en,
    input camera_pkg::vcount_t pattern_row
);

    // running totals of both credit loops since reset
    int out_beats;
    int credits_in;
    int req_accepted;
    int req_returned;
    // read back by the testbench at the end of the run
    int fail_count = 0;

    always @(posedge clk_camera) begin
        if (sys_rst_camera) begin
            out_beats <= 0;
            credits_in <= 0;
            req_accepted <= 0;
            req_returned <= 0;
        end else begin
            out_beats <= out_beats + int'(out_valid);
            credits_in <= credits_in + int'(out_credit);
            req_accepted <= req_accepted + int'(rd_req_valid);
            req_returned <= req_returned + int'(rd_req_credit);
        end
    end

    // a beat needs an initial or returned output credit
    out_credit_bound: assert property (@(posedge clk_camera) disable iff (sys_rst_camera)
        out_valid |-> out_beats < OUT_CREDITS + credits_in)
        else begin
            $error("out_valid beyond the output credits granted");
            fail_count++;
        end

    // outstanding requests stay between zero and REQ_DEPTH
    req_depth_bound: assert property (@(posedge clk_camera) disable iff (sys_rst_camera)
        req_returned <= req_accepted && req_accepted - req_returned <= REQ_DEPTH)
        else begin
            $error("request credits returned beyond accepted requests or queue overfilled");
            fail_count++;
        end

    // once every request is answered, every queue slot went back
    req_credit_balance: assert property (@(posedge clk_camera) disable iff (sys_rst_camera)
        out_beats == req_accepted |-> req_returned == req_accepted)
        else begin
            $error("rd_req_credit pulses differ from accepted requests while idle");
            fail_count++;
        end

    // control outputs and the pattern row come out of reset cleared
    reset_state: assert property (@(posedge clk_camera)
        sys_rst_camera |=> !out_valid && !rd_req_credit && wr_en == '0 && pattern_row == '0)
        else begin
            $error("control outputs not cleared after reset");
            fail_count++;
        end

endmodule

bind camera_reader camera_reader_sva #(
    .BANKS       (BANKS),
    .REQ_DEPTH   (REQ_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
) u_camera_reader_sva (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .rd_req_valid   (rd_req_valid),
    .rd_req_credit  (rd_req_credit),
    .out_valid      (out_valid),
    .out_credit     (out_credit),
    .wr_en          (wr_en),
    .pattern_row    (u_fb_write_router.pattern_row)
);

//--- verification/camera_reader_tb.sv
module camera_reader_tb;

    localparam int FB_W = 8;
    localparam int FB_H = 4;
    localparam int DS = 2;
    localparam int BANKS = 4;
    localparam int REQ_DEPTH = 4;
    localparam int OUT_CREDITS = 2;
    localparam int FB_SIZE = FB_W * FB_H;
    // limit for any single wait, and for the whole run
    localparam int WAIT_LIMIT = 2000;
    localparam int RUN_LIMIT = 20000;

    logic clk_camera;
    logic sys_rst_camera;
    logic [7:0] camera_d;
    logic cam_pclk;
    logic cam_hsync;
    logic cam_vsync;
    logic pattern_enable;
    logic rd_req_valid;
    camera_pkg::fb_addr_t rd_req_addr;
    logic out_credit;
    logic rd_req_credit;
    logic out_valid;
    camera_pkg::chan_t red;
    camera_pkg::chan_t green;
    camera_pkg::chan_t blue;
    camera_pkg::chan_t y;
    camera_pkg::chan_t cr;
    camera_pkg::chan_t cb;

    // reference frame buffer at downsampled addresses
    camera_pkg::pixel565_t model [FB_SIZE];
    // {red, green, blue, y, cr, cb} per pending read, in request order
    logic [47:0] expected_q [$];
    logic [31:0] lfsr_state;
    string test_name;
    logic sink_enable;
    int errors;
    int timeouts;
    int beats;
    int pending_credits;
    int credits_back;
    int reqs_sent;
    int frame_index;

    camera_reader #(
        .FB_W        (FB_W),
        .FB_H        (FB_H),
        .DS          (DS),
        .BANKS       (BANKS),
        .REQ_DEPTH   (REQ_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) camera_reader_i (
        .clk_camera     (clk_camera),
        .sys_rst_camera (sys_rst_camera),
        .camera_d       (camera_d),
        .cam_pclk       (cam_pclk),
        .cam_hsync      (cam_hsync),
        .cam_vsync      (cam_vsync),
        .pattern_enable (pattern_enable),
        .rd_req_valid   (rd_req_valid),
        .rd_req_addr    (rd_req_addr),
        .out_credit     (out_credit),
        .rd_req_credit  (rd_req_credit),
        .out_valid      (out_valid),
        .red            (red),
        .green          (green),
        .blue           (blue),
        .y              (y),
        .cr             (cr),
        .cb             (cb)
    );

    initial clk_camera = 1'b0;
    always #50 clk_camera = ~clk_camera;

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // weighted sum, rounding shift, offset, clamp
    function automatic logic [7:0] ycc_channel(input int r, input int g, input int b,
                                               input int kr, input int kg, input int kb,
                                               input int ofs);
        int v;
        v = ((kr * r + kg * g + kb * b + 128) >>> 8) + ofs;
        if (v < 0) begin
            v = 0;
        end else if (v > 255) begin
            v = 255;
        end
        return v[7:0];
    endfunction

    function automatic logic [47:0] expected_beat(input camera_pkg::fb_addr_t addr);
        camera_pkg::pixel565_t p;
        int r;
        int g;
        int b;
        // reads past the frame come back black
        p = 16'h0000;
        if (addr < FB_SIZE) begin
            p = model[addr];
        end
        r = {p[15:11], 3'b000};
        g = {p[10:5], 2'b00};
        b = {p[4:0], 3'b000};
        return {r[7:0], g[7:0], b[7:0],
                ycc_channel(r, g, b, camera_pkg::Y_R, camera_pkg::Y_G, camera_pkg::Y_B,
                            camera_pkg::Y_OFS),
                ycc_channel(r, g, b, camera_pkg::CR_R, camera_pkg::CR_G, camera_pkg::CR_B,
                            camera_pkg::C_OFS),
                ycc_channel(r, g, b, camera_pkg::CB_R, camera_pkg::CB_G, camera_pkg::CB_B,
                            camera_pkg::C_OFS)};
    endfunction

    task automatic hold(input int cycles);
        repeat (cycles) @(negedge clk_camera);
    endtask

    // pclk runs at a quarter of the system clock
    task automatic send_byte(input logic [7:0] d);
        camera_d = d;
        cam_pclk = 1'b0;
        hold(2);
        cam_pclk = 1'b1;
        hold(2);
    endtask

    task automatic send_frame(input logic use_pattern);
        logic [15:0] px;
        int a;
        pattern_enable = use_pattern;
        cam_vsync = 1'b1;
        hold(4);
        for (int v = 0; v < FB_H * DS; v++) begin
            cam_hsync = 1'b1;
            hold(4);
            for (int h = 0; h < FB_W * DS; h++) begin
                random_bits(16, px);
                // only grid pixels land in the buffer
                if (h % DS == 0 && v % DS == 0) begin
                    a = (v / DS) * FB_W + h / DS;
                    if (use_pattern) begin
                        model[a] = (v / DS < frame_index % FB_H) ? 16'hffff : 16'h0000;
                    end else begin
                        model[a] = px;
                    end
                end
                send_byte(px[15:8]);
                send_byte(px[7:0]);
            end
            hold(2);
            cam_hsync = 1'b0;
            hold(4);
        end
        // vsync falling bumps the pattern row
        cam_vsync = 1'b0;
        hold(4);
        frame_index++;
    endtask

    task automatic issue_read(input camera_pkg::fb_addr_t addr);
        int waited;
        waited = 0;
        while (REQ_DEPTH + credits_back - reqs_sent <= 0 && waited < WAIT_LIMIT) begin
            @(negedge clk_camera);
            waited++;
        end
        if (REQ_DEPTH + credits_back - reqs_sent <= 0) begin
            $display("timeout in %s: no request credit came back", test_name);
            timeouts++;
            return;
        end
        rd_req_valid = 1'b1;
        rd_req_addr = addr;
        reqs_sent++;
        expected_q.push_back(expected_beat(addr));
        @(negedge clk_camera);
        rd_req_valid = 1'b0;
    endtask

    task automatic read_frame();
        for (int a = 0; a < FB_SIZE; a++) begin
            issue_read(camera_pkg::fb_addr_t'(a));
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((expected_q.size() != 0 || pending_credits != 0) && waited < WAIT_LIMIT) begin
            @(negedge clk_camera);
            waited++;
        end
        if (expected_q.size() != 0 || pending_credits != 0) begin
            $display("timeout in %s: %0d read results never arrived", test_name,
                     expected_q.size());
            timeouts++;
            expected_q.delete();
        end
    endtask

    // queue slots come back one per rd_req_credit pulse
    always @(posedge clk_camera) begin
        if (sys_rst_camera) begin
            credits_back <= 0;
        end else if (rd_req_credit) begin
            credits_back <= credits_back + 1;
        end
    end

    // scoreboard and credit sink
    always @(negedge clk_camera) begin : scoreboard
        logic [47:0] exp_beat;
        out_credit = 1'b0;
        if (!sys_rst_camera && out_valid) begin
            beats++;
            pending_credits++;
            if (expected_q.size() == 0) begin
                $display("unexpected out_valid in %s with no read pending", test_name);
                errors++;
            end else begin
                exp_beat = expected_q.pop_front();
                assert ({red, green, blue, y, cr, cb} == exp_beat) else begin
                    $display("Error %s: expected %h actual %h", test_name, exp_beat,
                             {red, green, blue, y, cr, cb});
                    errors++;
                end
            end
        end
        // one credit back per cycle while the sink is open
        if (sink_enable && pending_credits > 0) begin
            out_credit = 1'b1;
            pending_credits--;
        end
    end

    initial begin
        repeat (RUN_LIMIT) @(posedge clk_camera);
        $display("run passed %0d cycles without finishing", RUN_LIMIT);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int stall_start;
        int sva_fails;
        lfsr_state = 32'h9f28931e;
        errors = 0;
        timeouts = 0;
        beats = 0;
        pending_credits = 0;
        reqs_sent = 0;
        frame_index = 0;
        sink_enable = 1'b1;
        test_name = "reset";
        sys_rst_camera = 1'b1;
        camera_d = '0;
        cam_pclk = 1'b0;
        cam_hsync = 1'b0;
        cam_vsync = 1'b0;
        pattern_enable = 1'b0;
        rd_req_valid = 1'b0;
        rd_req_addr = '0;
        out_credit = 1'b0;
        repeat (2) @(negedge clk_camera);
        sys_rst_camera = 1'b0;

        // random camera frame read back whole, colour conversion checked per beat
        test_name = "camera_frame";
        send_frame(1'b0);
        hold(10);
        read_frame();
        wait_drain();

        test_name = "out_of_frame";
        issue_read(camera_pkg::fb_addr_t'(FB_SIZE));
        issue_read(camera_pkg::fb_addr_t'(FB_SIZE + 7));
        issue_read(17'h1ffff);
        wait_drain();

        // sink closed, only the initial output credits may drain
        test_name = "credit_stall";
        sink_enable = 1'b0;
        stall_start = beats;
        for (int i = 0; i < OUT_CREDITS + REQ_DEPTH; i++) begin
            issue_read(camera_pkg::fb_addr_t'((i * 5) % FB_SIZE));
        end
        hold(20);
        assert (beats - stall_start == OUT_CREDITS) else begin
            $display("Error %s: expected %0d actual %0d", test_name, OUT_CREDITS,
                     beats - stall_start);
            errors++;
        end
        sink_enable = 1'b1;
        wait_drain();

        // frames 1 to FB_H, the last one wraps back to all black
        test_name = "pattern";
        for (int f = 0; f < FB_H; f++) begin
            send_frame(1'b1);
            hold(10);
            read_frame();
            wait_drain();
        end
        pattern_enable = 1'b0;

        sva_fails = camera_reader_i.u_camera_reader_sva.fail_count;
        $display("checks done: %0d errors, %0d timeouts, %0d assertion failures",
                 errors, timeouts, sva_fails);
        if (errors == 0 && timeouts == 0 && sva_fails == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- verilog.f
common/camera_pkg.sv
pixel/pixel_reconstruct.sv
pixel/rgb_to_ycrcb.sv
frame_buffer/fb_write_router.sv
frame_buffer/fb_bank.sv
frame_buffer/fb_read_scheduler.sv
design/camera_reader.sv
verification/camera_reader_sva.sv
verification/camera_reader_tb.sv
